// File: hw/rv_core_pkg.sv
////////////////////
// Instruction-side core package
// Widths, encodings and bus records shared by fetch, buffer and execute
////////////////////

package rv_core_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int unsigned XLEN        = 32;
  localparam int unsigned REG_ADDR_W  = 5;
  localparam int unsigned NUM_REGS    = 32;
  localparam int unsigned FIFO_DEPTH  = 4;
  localparam int unsigned FIFO_PTR_W  = 2;
  localparam int unsigned INSTR_BYTES = 4;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT
  } fetch_state_e;

  ////////////////////
  // Records
  ////////////////////

  // Instruction bus, core to memory
  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
  } instr_req_t;

  // Instruction bus, memory to core
  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
    logic            err;
  } instr_rsp_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic            err;
  } fetch_entry_t;

  // Reduced formal-interface retire record
  typedef struct packed {
    logic                  valid;
    logic                  trap;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       insn;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
  } retire_t;

endpackage

// File: hw/rv_core_top.sv
////////////////////
// Instruction-side core top
// Fetch unit, prefetch FIFO and execute unit in a chain
////////////////////

`timescale 1ns/100ps

module rv_core_top (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic [31:0]             boot_addr_i,
  input  logic                    fetch_enable_i,
  output rv_core_pkg::instr_req_t instr_req_o,
  input  rv_core_pkg::instr_rsp_t instr_rsp_i,
  output rv_core_pkg::retire_t    retire_o
);

  import rv_core_pkg::*;

  // Fetch to buffer
  logic         push;
  fetch_entry_t push_entry;
  logic         fifo_full;

  // Buffer to execute
  logic         fifo_valid;
  fetch_entry_t pop_entry;
  logic         pop;

  rv_fetch_unit i_fetch_unit (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_req_o    (instr_req_o),
    .instr_rsp_i    (instr_rsp_i),
    .push_o         (push),
    .push_entry_o   (push_entry),
    .fifo_full_i    (fifo_full),
    .fifo_pop_i     (pop)
  );

  rv_prefetch_fifo i_prefetch_fifo (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_entry_i (push_entry),
    .full_o       (fifo_full),
    .pop_i        (pop),
    .valid_o      (fifo_valid),
    .pop_entry_o  (pop_entry)
  );

  rv_exec_unit i_exec_unit (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .entry_valid_i (fifo_valid),
    .entry_i       (pop_entry),
    .pop_o         (pop),
    .retire_o      (retire_o)
  );

endmodule

// File: hw/rv_exec_unit.sv
////////////////////
// Execute unit
// Decode, ALU and retire record for the reduced RV32I integer subset
////////////////////

`timescale 1ns/100ps

module rv_exec_unit (
  input  logic                      clk,
  input  logic                      rst_ni,
  input  logic                      entry_valid_i,
  input  rv_core_pkg::fetch_entry_t entry_i,
  output logic                      pop_o,
  output rv_core_pkg::retire_t      retire_o
);

  import rv_core_pkg::*;

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_u;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       operand_b;
  logic [XLEN-1:0]       alu_result;
  alu_op_e               alu_op;
  logic                  use_imm_i;
  logic                  use_imm_u;
  logic                  illegal;
  logic                  trap;
  logic                  rd_we;
  retire_t               retire_d;
  retire_t               retire_q;

  // Never stalls
  assign pop_o = entry_valid_i;

  ////////////////////
  // Decode
  ////////////////////

  assign opcode   = opcode_e'(entry_i.instr[6:0]);
  assign rd_addr  = entry_i.instr[11:7];
  assign funct3   = entry_i.instr[14:12];
  assign rs1_addr = entry_i.instr[19:15];
  assign rs2_addr = entry_i.instr[24:20];
  assign funct7   = entry_i.instr[31:25];

  assign imm_i = {{(XLEN - 12){entry_i.instr[31]}}, entry_i.instr[31:20]};
  assign imm_u = {entry_i.instr[31:12], 12'b0};

  always_comb begin
    alu_op    = ALU_ADD;
    use_imm_i = 1'b0;
    use_imm_u = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        use_imm_i = 1'b1;
        case (funct3)
          3'b000:  alu_op = ALU_ADD;
          3'b010:  alu_op = ALU_SLT;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: illegal = 1'b1;
        endcase
      end
      OPC_OP: begin
        if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          alu_op = ALU_SUB;
        end else if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  alu_op = ALU_ADD;
            3'b010:  alu_op = ALU_SLT;
            3'b100:  alu_op = ALU_XOR;
            3'b110:  alu_op = ALU_OR;
            3'b111:  alu_op = ALU_AND;
            default: illegal = 1'b1;
          endcase
        end else begin
          illegal = 1'b1;
        end
      end
      OPC_LUI: begin
        use_imm_u = 1'b1;
        alu_op    = ALU_PASS_B;
      end
      default: illegal = 1'b1;
    endcase
  end

  ////////////////////
  // ALU
  ////////////////////

  assign operand_b = use_imm_u ? imm_u : (use_imm_i ? imm_i : rs2_data);

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = rs1_data + operand_b;
      ALU_SUB:    alu_result = rs1_data - operand_b;
      ALU_AND:    alu_result = rs1_data & operand_b;
      ALU_OR:     alu_result = rs1_data | operand_b;
      ALU_XOR:    alu_result = rs1_data ^ operand_b;
      ALU_SLT:    alu_result = {{(XLEN - 1){1'b0}}, $signed(rs1_data) < $signed(operand_b)};
      ALU_PASS_B: alu_result = operand_b;
      default:    alu_result = '0;
    endcase
  end

  // Traps and writes to x0 leave the register file untouched
  assign trap  = illegal | entry_i.err;
  assign rd_we = ~trap & (rd_addr != '0);

  rv_reg_file i_reg_file (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .we_i      (entry_valid_i & rd_we),
    .waddr_i   (rd_addr),
    .wdata_i   (alu_result)
  );

  ////////////////////
  // Retire
  ////////////////////

  always_comb begin
    retire_d.valid    = 1'b1;
    retire_d.trap     = trap;
    retire_d.pc       = entry_i.pc;
    retire_d.insn     = entry_i.instr;
    retire_d.rd_addr  = rd_we ? rd_addr : '0;
    retire_d.rd_wdata = rd_we ? alu_result : '0;
  end

  // One valid cycle per popped entry
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_q <= '0;
    end else if (entry_valid_i) begin
      retire_q <= retire_d;
    end else begin
      retire_q.valid <= 1'b0;
    end
  end

  assign retire_o = retire_q;

endmodule

// File: hw/rv_fetch_unit.sv
////////////////////
// Instruction fetch unit
// Sequential word fetch over the req/gnt/rvalid bus, one request at a time
////////////////////

`timescale 1ns/100ps

module rv_fetch_unit (
  input  logic                      clk,
  input  logic                      rst_ni,
  input  logic [31:0]               boot_addr_i,
  input  logic                      fetch_enable_i,
  output rv_core_pkg::instr_req_t   instr_req_o,
  input  rv_core_pkg::instr_rsp_t   instr_rsp_i,
  output logic                      push_o,
  output rv_core_pkg::fetch_entry_t push_entry_o,
  input  logic                      fifo_full_i,
  input  logic                      fifo_pop_i
);

  import rv_core_pkg::*;

  fetch_state_e        state_q, state_d;
  logic [XLEN-1:0]     pc_q;
  logic [XLEN-1:0]     fetch_pc;
  logic [XLEN-1:0]     rsp_pc_q;
  logic                booted_q;
  logic [FIFO_PTR_W:0] count_q, count_d;
  logic                slot_free;
  logic                grant;

  // Boot address is used until the first grant
  assign fetch_pc = booted_q ? pc_q : boot_addr_i;

  assign grant  = (state_q == FETCH_REQ) & instr_rsp_i.gnt;
  assign push_o = (state_q == FETCH_WAIT) & instr_rsp_i.rvalid;

  // Buffer occupancy as seen after this edge
  assign count_d = count_q + (FIFO_PTR_W + 1)'(push_o) - (FIFO_PTR_W + 1)'(fifo_pop_i);

  // Room for one more word once the current one has landed
  assign slot_free = (count_d < (FIFO_PTR_W + 1)'(FIFO_DEPTH)) &
                     ~(fifo_full_i & ~fifo_pop_i);

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (fetch_enable_i && slot_free) begin
          state_d = FETCH_REQ;
        end
      end
      // Address phase holds until granted, even with fetch disabled
      FETCH_REQ: begin
        if (instr_rsp_i.gnt) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_rsp_i.rvalid) begin
          state_d = (fetch_enable_i && slot_free) ? FETCH_REQ : FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= FETCH_IDLE;
      booted_q <= 1'b0;
      pc_q     <= '0;
      count_q  <= '0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
      if (grant) begin
        pc_q     <= fetch_pc + XLEN'(INSTR_BYTES);
        booted_q <= 1'b1;
      end
    end
  end

  // PC of the word in flight
  always_ff @(posedge clk) begin
    if (grant) begin
      rsp_pc_q <= fetch_pc;
    end
  end

  assign instr_req_o.req  = (state_q == FETCH_REQ);
  assign instr_req_o.addr = fetch_pc;

  assign push_entry_o.pc    = rsp_pc_q;
  assign push_entry_o.instr = instr_rsp_i.rdata;
  assign push_entry_o.err   = instr_rsp_i.err;

endmodule

// File: hw/rv_prefetch_fifo.sv
////////////////////
// Prefetch FIFO
// Holds fetched words in order between fetch and execute
////////////////////

`timescale 1ns/100ps

module rv_prefetch_fifo (
  input  logic                      clk,
  input  logic                      rst_ni,
  input  logic                      push_i,
  input  rv_core_pkg::fetch_entry_t push_entry_i,
  output logic                      full_o,
  input  logic                      pop_i,
  output logic                      valid_o,
  output rv_core_pkg::fetch_entry_t pop_entry_o
);

  import rv_core_pkg::*;

  fetch_entry_t          mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wptr_q, rptr_q;
  logic [FIFO_PTR_W:0]   count_q;
  logic                  push_ok;
  logic                  pop_ok;

  assign full_o  = (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
  assign valid_o = (count_q != '0);

  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & valid_o;

  // Head entry is presented directly
  assign pop_entry_o = mem_q[rptr_q];

  ////////////////////
  // Pointers
  ////////////////////

  // Depth is a power of two so pointers wrap on their own
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_ok) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop_ok) begin
        rptr_q <= rptr_q + 1'b1;
      end
      count_q <= count_q + (FIFO_PTR_W + 1)'(push_ok) - (FIFO_PTR_W + 1)'(pop_ok);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem_q[wptr_q] <= push_entry_i;
    end
  end

endmodule

// File: hw/rv_reg_file.sv
////////////////////
// Integer register file
// 32 x 32 flops, two async read ports, one write port, x0 fixed at zero
////////////////////

`timescale 1ns/100ps

module rv_reg_file (
  input  logic                               clk,
  input  logic                               rst_ni,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_b_o,
  input  logic                               we_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_core_pkg::XLEN-1:0]       wdata_i
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] regs_q [NUM_REGS];

  // Entry zero is cleared at reset and never written
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and check the log

LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --timescale 1ns/100ps \
  --top-module tb_rv_core \
  -f sources.f \
  -o sim_tb \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb > "$LOG" 2>&1 \
  || { cat "$LOG"; echo "Simulation did not complete"; exit 1; }

cat "$LOG"

grep -qx "No errors" "$LOG" && echo "Result: PASS" \
  || { echo "Result: FAIL"; exit 1; }

// File: sources.f
hw/rv_core_pkg.sv
hw/rv_reg_file.sv
hw/rv_fetch_unit.sv
hw/rv_prefetch_fifo.sv
hw/rv_exec_unit.sv
hw/rv_core_top.sv
tb/tb_rv_core.sv

// File: tb/core_trace.txt
# B boot_addr | P insn err | N retire count (decimal) | all other fields hex
# R trap pc insn rd_addr rd_wdata
B 00001000
P 00500093 0
P ffd00113 0
P 002081b3 0
P 40208233 0
P 0020f2b3 0
P 0020e333 0
P 0020c3b3 0
P 00112433 0
P fff0a493 0
P 12345537 0
P 67856513 0
P fff54593 0
P 0f05f613 0
P 00708013 0
P 001006b3 0
P 00109093 0
P 06300093 1
P 00008713 0
N 18
R 0 00001000 00500093 01 00000005
R 0 00001004 ffd00113 02 fffffffd
R 0 00001008 002081b3 03 00000002
R 0 0000100c 40208233 04 00000008
R 0 00001010 0020f2b3 05 00000005
R 0 00001014 0020e333 06 fffffffd
R 0 00001018 0020c3b3 07 fffffff8
R 0 0000101c 00112433 08 00000001
R 0 00001020 fff0a493 09 00000000
R 0 00001024 12345537 0a 12345000
R 0 00001028 67856513 0a 12345678
R 0 0000102c fff54593 0b edcba987
R 0 00001030 0f05f613 0c 00000080
R 0 00001034 00708013 00 00000000
R 0 00001038 001006b3 0d 00000005
R 1 0000103c 00109093 00 00000000
R 1 00001040 06300093 00 00000000
R 0 00001044 00008713 0e 00000005

// File: tb/tb_rv_core.sv
////////////////////
// Instruction-side core testbench
// Random-latency instruction memory, trace-driven retire checks and bus checks
////////////////////

`timescale 1ns/100ps

module tb_rv_core;

  import rv_core_pkg::*;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_ADDR,
    MEM_DATA
  } mem_phase_e;

  logic        clk;
  logic        rst_ni;
  logic [31:0] boot_addr;
  logic        fetch_enable;
  instr_req_t  instr_req;
  instr_rsp_t  instr_rsp;
  retire_t     retire;

  // Trace contents
  logic [31:0] prog_words[$];
  bit          prog_errs[$];
  retire_t     exp_q[$];
  int          exp_count;

  // Memory model state
  mem_phase_e  phase;
  instr_req_t  held_req;
  int          gnt_wait;
  int          rv_wait;
  int          n_grants;
  int          n_pushes;

  int          seed = 32'h4540_c5ad;
  int          errors;
  int          cycles;
  int          cycle_limit;
  int          n_checked;
  int          n_retired;
  bit          timed_out;
  bit          trace_ok;

  rv_core_top i_dut (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr),
    .fetch_enable_i (fetch_enable),
    .instr_req_o    (instr_req),
    .instr_rsp_i    (instr_rsp),
    .retire_o       (retire)
  );

  always #5 clk = ~clk;

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_retire(input retire_t got, input retire_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s: got v=%0b trap=%0b pc=%h insn=%h rd=%0d wdata=%h", $time, what,
               got.valid, got.trap, got.pc, got.insn, got.rd_addr, got.rd_wdata);
      $display("     expected v=%0b trap=%0b pc=%h insn=%h rd=%0d wdata=%h",
               exp.valid, exp.trap, exp.pc, exp.insn, exp.rd_addr, exp.rd_wdata);
    end
  endtask

  // Address only matters while a request is expected
  task automatic check_bus(input instr_req_t got, input instr_req_t exp, input string what);
    if (got.req !== exp.req || (exp.req && got.addr !== exp.addr)) begin
      errors++;
      $display("FAIL %0t: %s: got req=%0b addr=%h, expected req=%0b addr=%h", $time, what,
               got.req, got.addr, exp.req, exp.addr);
    end
  endtask

  ////////////////////
  // Trace reader
  ////////////////////

  task automatic read_trace(output bit ok);
    int          fd;
    int          c;
    int          n;
    logic [31:0] f0, f1, f2, f3, f4;
    retire_t     rec;
    ok = 1'b0;
    fd = $fopen("tb/core_trace.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      c  = $fgetc(fd);
      while (c != -1) begin
        if (c == int'("#")) begin
          while (c != -1 && c != int'("\n")) begin
            c = $fgetc(fd);
          end
        end else if (c == int'("B")) begin
          n = $fscanf(fd, " %h", boot_addr);
          ok &= (n == 1);
        end else if (c == int'("P")) begin
          n = $fscanf(fd, " %h %h", f0, f1);
          ok &= (n == 2);
          prog_words.push_back(f0);
          prog_errs.push_back(f1[0]);
        end else if (c == int'("N")) begin
          n = $fscanf(fd, " %d", exp_count);
          ok &= (n == 1);
        end else if (c == int'("R")) begin
          n = $fscanf(fd, " %h %h %h %h %h", f0, f1, f2, f3, f4);
          ok &= (n == 5);
          rec.valid    = 1'b1;
          rec.trap     = f0[0];
          rec.pc       = f1;
          rec.insn     = f2;
          rec.rd_addr  = f3[REG_ADDR_W-1:0];
          rec.rd_wdata = f4;
          exp_q.push_back(rec);
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  ////////////////////
  // Monitor and memory model
  ////////////////////

  task automatic observe_retire();
    if (retire.valid) begin
      n_retired++;
      // Padding words past the program retire unchecked
      if (n_checked < exp_count) begin
        check_retire(retire, exp_q[n_checked], $sformatf("retire %0d", n_checked));
        n_checked++;
      end
    end
    if (n_pushes - n_retired > int'(FIFO_DEPTH)) begin
      errors++;
      $display("FAIL %0t: buffer holds %0d words, limit %0d", $time,
               n_pushes - n_retired, FIFO_DEPTH);
    end
  endtask

  task automatic model_bus(input logic fe);
    instr_req_t exp_req;
    int         word_idx;
    instr_rsp = '0;
    exp_req   = '0;
    case (phase)
      MEM_IDLE: begin
        if (instr_req.req) begin
          if (!fe) begin
            errors++;
            $display("FAIL %0t: request started while fetch enable was low", $time);
          end
          exp_req.req  = 1'b1;
          exp_req.addr = boot_addr + n_grants * INSTR_BYTES;
          check_bus(instr_req, exp_req, "request address");
          held_req = instr_req;
          gnt_wait = int'($unsigned($random(seed)) % 4);
          phase    = MEM_ADDR;
        end
      end
      MEM_ADDR: check_bus(instr_req, held_req, "request held until grant");
      default:  check_bus(instr_req, exp_req, "request before rvalid");
    endcase
    if (phase == MEM_ADDR) begin
      if (gnt_wait == 0) begin
        instr_rsp.gnt = 1'b1;
        n_grants++;
        rv_wait = 1 + int'($unsigned($random(seed)) % 3);
        phase   = MEM_DATA;
      end else begin
        gnt_wait--;
      end
    end else if (phase == MEM_DATA) begin
      rv_wait--;
      if (rv_wait == 0) begin
        word_idx         = int'((held_req.addr - boot_addr) >> 2);
        instr_rsp.rvalid = 1'b1;
        if (word_idx < prog_words.size()) begin
          instr_rsp.rdata = prog_words[word_idx];
          instr_rsp.err   = prog_errs[word_idx];
        end else begin
          // ADDI x0, x0, 0
          instr_rsp.rdata = 32'h0000_0013;
        end
        n_pushes++;
        phase = MEM_IDLE;
      end
    end
  endtask

  // Inputs sampled at the edge, outputs observed 1 ns later
  always @(posedge clk) begin : monitor
    logic fe_seen;
    logic in_reset;
    fe_seen  = fetch_enable;
    in_reset = ~rst_ni;
    #1;
    cycles++;
    if (cycles >= cycle_limit) begin
      timed_out = 1'b1;
    end
    if (in_reset) begin
      check_bus(instr_req, '0, "request during reset");
      check_retire(retire, '0, "retire during reset");
    end else begin
      observe_retire();
      model_bus(fe_seen);
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic run_program();
    repeat (8) @(posedge clk);
    #1 rst_ni = 1'b1;
    @(posedge clk);
    #1 fetch_enable = 1'b1;
    // Pause fetch a third of the way through
    while (n_checked < exp_count / 3 && !timed_out) @(posedge clk);
    #1 fetch_enable = 1'b0;
    repeat (20) @(posedge clk);
    #1 fetch_enable = 1'b1;
    while (n_checked < exp_count && !timed_out) @(posedge clk);
    if (timed_out) begin
      errors++;
      $display("Timeout after %0d cycles with %0d of %0d retirements missing", cycles,
               exp_count - n_checked, exp_count);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_ni       = 1'b0;
    boot_addr    = '0;
    fetch_enable = 1'b0;
    instr_rsp    = '0;
    phase        = MEM_IDLE;
    read_trace(trace_ok);
    cycle_limit = 40 * exp_count + 100;
    if (!trace_ok) begin
      errors++;
      $display("Could not read the trace file tb/core_trace.txt");
    end else if (exp_q.size() != exp_count) begin
      errors++;
      $display("Trace holds %0d retire records but announces %0d", exp_q.size(), exp_count);
    end else begin
      run_program();
    end
    $display("Checked %0d of %0d retirements, %0d errors", n_checked, exp_count, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
